// File: verilog/rdma_resp_macros.svh
`ifndef RDMA_RESP_MACROS_SVH
`define RDMA_RESP_MACROS_SVH

`define DATA_W            512
`define KEEP_W            64
`define HDR_BYTES         58      // eth + ipv4 + udp + bth + aeth
`define RD_RESP_BYTES     314     // header plus 256 byte payload
`define NUM_RD_RESP       8
`define NUM_ACK           8
`define QP_TABLE_DEPTH    8
`define IP_TOTAL_LEN_RD   16'h0130
`define IP_TOTAL_LEN_ACK  16'h0030
`define OPC_RD_RESP       8'h10
`define OPC_ACK           8'h11
`define ETH_TYPE_IPV4     16'h0800
`define IP_VER_IHL        8'h45
`define IP_TOS            8'hb8
`define IP_ID             16'h5555
`define IP_FLAGS          16'h4000   // don't fragment
`define IP_TTL            8'hba
`define IP_PROTO_UDP      8'h11
`define UDP_SRC_PORT      16'h6851
`define UDP_DST_PORT      16'h12b7   // rocev2
`define BTH_PKEY          16'h666f
`define DESC_QP_BYTE      47
`define DESC_PSN_BYTE     51
`endif

// File: verilog/rdma_resp_pkg.sv
`include "rdma_resp_macros.svh"

package rdma_resp_pkg;

  typedef struct packed {
    logic [47:0] src_mac;
    logic [31:0] src_ip;
  } local_cfg_t;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
  } qp_dest_t;

  typedef enum logic {
    KIND_RD_RESP = 1'b0,
    KIND_ACK     = 1'b1
  } pkt_kind_t;

  // header already byte reversed, byte 0 sits in bits 7:0
  typedef struct packed {
    logic [`HDR_BYTES*8-1:0] hdr;
    pkt_kind_t               kind;
    logic [3:0]              resp_idx;   // 1..8 within a phase
  } pkt_job_t;

  // ones complement sum over the 20 byte ipv4 header, csum field zero
  function automatic logic [15:0] ipv4_checksum(input logic [159:0] ip_hdr);
    logic [19:0] sum;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 20'(ip_hdr[i*16 +: 16]);
    end
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);   // second fold for the carry
    return ~sum[15:0];
  endfunction

  function automatic logic [`HDR_BYTES*8-1:0] hdr_to_wire(input logic [`HDR_BYTES*8-1:0] hdr);
    logic [`HDR_BYTES*8-1:0] wire_hdr;
    for (int i = 0; i < `HDR_BYTES; i++) begin
      wire_hdr[i*8 +: 8] = hdr[(`HDR_BYTES-1-i)*8 +: 8];
    end
    return wire_hdr;
  endfunction

endpackage

// File: verilog/rdma_resp_seq.sv
`timescale 1ns/10ps
`include "rdma_resp_macros.svh"

module rdma_resp_seq (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      conf_of_reg_done_i,
  input  rdma_resp_pkg::local_cfg_t local_cfg_i,
  input  rdma_resp_pkg::qp_dest_t   qp_table_i [`QP_TABLE_DEPTH],
  input  logic [`DATA_W-1:0]        wqe_tdata_i,
  input  logic                      wqe_tvalid_i,
  input  logic                      wqe_tlast_i,
  output logic                      post_rdma_rd_wqe_o,
  output logic                      post_rdma_wr_wqe_o,
  output logic                      rd_path_done_o,
  output logic                      wr_path_done_o,
  input  logic                      buf_full_i,
  output logic                      job_push_o,
  output rdma_resp_pkg::pkt_job_t   job_o
);
  import rdma_resp_pkg::*;

  localparam int QP_IDX_W = $clog2(`QP_TABLE_DEPTH);

  typedef enum logic [2:0] {
    S_START,
    S_WAIT,
    S_TLAST,
    S_BUILD,
    S_PUSH,
    S_DONE
  } seq_state_e;

  seq_state_e              state_q;
  pkt_kind_t               phase_q;
  logic [3:0]              round_q;
  logic                    last_round;
  logic                    desc_take;
  logic [23:0]             rcvd_qp_q;
  logic [23:0]             rcvd_psn_q;
  qp_dest_t                dest;
  logic [15:0]             ip_total_len;
  logic [15:0]             udp_len;
  logic [7:0]              bth_opcode;
  logic [159:0]            ip_hdr;
  logic [15:0]             ip_csum;
  logic [`HDR_BYTES*8-1:0] hdr_be;
  pkt_job_t                job_q;

  assign desc_take  = (state_q == S_WAIT) && wqe_tvalid_i;
  assign last_round = (phase_q == KIND_ACK) ? (round_q == 4'(`NUM_ACK - 1))
                                            : (round_q == 4'(`NUM_RD_RESP - 1));

  // table lookup on the low qp bits
  assign dest = qp_table_i[rcvd_qp_q[QP_IDX_W-1:0]];

  assign ip_total_len = (phase_q == KIND_ACK) ? `IP_TOTAL_LEN_ACK : `IP_TOTAL_LEN_RD;
  assign udp_len      = ip_total_len - 16'd20;
  assign bth_opcode   = (phase_q == KIND_ACK) ? `OPC_ACK : `OPC_RD_RESP;

  assign ip_hdr = {`IP_VER_IHL, `IP_TOS, ip_total_len, `IP_ID, `IP_FLAGS, `IP_TTL,
                   `IP_PROTO_UDP, 16'h0000, local_cfg_i.src_ip, dest.dst_ip};
  assign ip_csum = ipv4_checksum(ip_hdr);

  // big endian field order, first wire byte in the msb
  assign hdr_be = {dest.dst_mac, local_cfg_i.src_mac, `ETH_TYPE_IPV4,
                   ip_hdr[159:80], ip_csum, ip_hdr[63:0],
                   `UDP_SRC_PORT, `UDP_DST_PORT, udp_len, 16'h0000,
                   bth_opcode, 8'h00, `BTH_PKEY, 8'h00, rcvd_qp_q, 8'h00, rcvd_psn_q,
                   32'h0000_0000};   // aeth

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q            <= S_START;
      phase_q            <= KIND_RD_RESP;
      round_q            <= '0;
      post_rdma_rd_wqe_o <= 1'b0;
      post_rdma_wr_wqe_o <= 1'b0;
      rd_path_done_o     <= 1'b0;
      wr_path_done_o     <= 1'b0;
    end else begin
      post_rdma_rd_wqe_o <= 1'b0;
      post_rdma_wr_wqe_o <= 1'b0;
      case (state_q)
        S_START: begin
          if (conf_of_reg_done_i) begin
            post_rdma_rd_wqe_o <= (phase_q == KIND_RD_RESP);
            post_rdma_wr_wqe_o <= (phase_q == KIND_ACK);
            state_q            <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (wqe_tvalid_i) begin
            state_q <= wqe_tlast_i ? S_BUILD : S_TLAST;
          end
        end
        S_TLAST: begin
          if (wqe_tlast_i) begin   // descriptor already captured
            state_q <= S_BUILD;
          end
        end
        S_BUILD: state_q <= S_PUSH;
        S_PUSH: begin
          if (!buf_full_i) begin
            if (last_round) begin
              round_q <= '0;
              if (phase_q == KIND_RD_RESP) begin
                rd_path_done_o <= 1'b1;
                phase_q        <= KIND_ACK;
                state_q        <= S_START;
              end else begin
                wr_path_done_o <= 1'b1;
                state_q        <= S_DONE;
              end
            end else begin
              round_q <= round_q + 4'd1;
              state_q <= S_START;
            end
          end
        end
        default: state_q <= S_DONE;   // both phases finished
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (desc_take) begin
      rcvd_qp_q  <= {wqe_tdata_i[`DESC_QP_BYTE*8 +: 8],
                     wqe_tdata_i[(`DESC_QP_BYTE+1)*8 +: 8],
                     wqe_tdata_i[(`DESC_QP_BYTE+2)*8 +: 8]};
      rcvd_psn_q <= {wqe_tdata_i[`DESC_PSN_BYTE*8 +: 8],
                     wqe_tdata_i[(`DESC_PSN_BYTE+1)*8 +: 8],
                     wqe_tdata_i[(`DESC_PSN_BYTE+2)*8 +: 8]};
    end
    if (state_q == S_BUILD) begin
      job_q.hdr      <= hdr_to_wire(hdr_be);
      job_q.kind     <= phase_q;
      job_q.resp_idx <= round_q + 4'd1;
    end
  end

  assign job_push_o = (state_q == S_PUSH) && !buf_full_i;
  assign job_o      = job_q;

endmodule

// File: verilog/rdma_pkt_buffer.sv
`timescale 1ns/10ps

module rdma_pkt_buffer (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  logic                    push_i,
  input  rdma_resp_pkg::pkt_job_t job_i,
  output logic                    full_o,
  input  logic                    pop_i,
  output logic                    empty_o,
  output rdma_resp_pkg::pkt_job_t job_o
);
  import rdma_resp_pkg::*;

  localparam int DEPTH = 2;
  localparam int PTR_W = $clog2(DEPTH);

  pkt_job_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign job_o   = mem_q[rd_ptr_q];   // head, valid while not empty

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (do_pop) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + (PTR_W+1)'(1);
        2'b01:   count_q <= count_q - (PTR_W+1)'(1);
        default: count_q <= count_q;   // idle or push with pop
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= job_i;
    end
  end

endmodule

// File: verilog/rdma_beat_tx.sv
`timescale 1ns/10ps
`include "rdma_resp_macros.svh"

module rdma_beat_tx (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  logic                    empty_i,
  input  rdma_resp_pkg::pkt_job_t job_i,
  output logic                    pop_o,
  output logic [`DATA_W-1:0]      tx_tdata_o,
  output logic [`KEEP_W-1:0]      tx_tkeep_o,
  output logic                    tx_tvalid_o,
  output logic                    tx_tlast_o,
  input  logic                    tx_tready_i
);
  import rdma_resp_pkg::*;

  pkt_job_t           job_q;
  logic [2:0]         beat_q;     // next beat of job_q to present
  logic               more_q;
  logic               tx_free;
  logic               load_beat;
  pkt_job_t           cur_job;
  logic [2:0]         cur_beat;
  logic [9:0]         pkt_len;
  logic               last_beat;
  logic [`DATA_W-1:0] hdr_lanes;
  logic [7:0]         pay_byte;
  logic [`DATA_W-1:0] beat_data;
  logic [`KEEP_W-1:0] beat_keep;

  // output regs may change when empty or when the beat is taken
  assign tx_free   = !tx_tvalid_o || tx_tready_i;
  assign pop_o     = tx_free && !more_q && !empty_i;
  assign load_beat = pop_o || (tx_free && more_q);

  // a popped job feeds beat 0 straight from the buffer head
  assign cur_job  = pop_o ? job_i : job_q;
  assign cur_beat = pop_o ? 3'd0 : beat_q;

  assign pkt_len   = (cur_job.kind == KIND_ACK) ? 10'(`HDR_BYTES) : 10'(`RD_RESP_BYTES);
  assign last_beat = ((10'(cur_beat) + 10'd1) * 10'(`KEEP_W)) >= pkt_len;
  assign hdr_lanes = `DATA_W'(cur_job.hdr);
  assign pay_byte  = {4'h1, cur_job.resp_idx};

  always_comb begin
    logic [9:0] byte_pos;
    beat_data = '0;
    beat_keep = '0;
    for (int lane = 0; lane < `KEEP_W; lane++) begin
      byte_pos = 10'(cur_beat) * 10'(`KEEP_W) + 10'(lane);
      if (byte_pos < pkt_len) begin
        beat_keep[lane] = 1'b1;
        if (byte_pos < 10'(`HDR_BYTES)) begin   // only on beat 0
          beat_data[lane*8 +: 8] = hdr_lanes[lane*8 +: 8];
        end else begin
          beat_data[lane*8 +: 8] = pay_byte;
        end
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      tx_tvalid_o <= 1'b0;
      tx_tlast_o  <= 1'b0;
      more_q      <= 1'b0;
      beat_q      <= '0;
    end else if (tx_free) begin
      if (load_beat) begin
        tx_tvalid_o <= 1'b1;
        tx_tlast_o  <= last_beat;
        more_q      <= !last_beat;
        beat_q      <= cur_beat + 3'd1;
      end else begin
        tx_tvalid_o <= 1'b0;
        tx_tlast_o  <= 1'b0;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (pop_o) begin
      job_q <= job_i;
    end
    if (tx_free && load_beat) begin
      tx_tdata_o <= beat_data;
      tx_tkeep_o <= beat_keep;
    end
  end

endmodule

// File: verilog/rdma_resp_top.sv
`timescale 1ns/10ps
`include "rdma_resp_macros.svh"

module rdma_resp_top (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      conf_of_reg_done_i,
  input  rdma_resp_pkg::local_cfg_t local_cfg_i,
  input  rdma_resp_pkg::qp_dest_t   qp_table_i [`QP_TABLE_DEPTH],
  input  logic [`DATA_W-1:0]        wqe_tdata_i,
  input  logic                      wqe_tvalid_i,
  input  logic                      wqe_tlast_i,
  output logic                      post_rdma_rd_wqe_o,
  output logic                      post_rdma_wr_wqe_o,
  output logic                      rd_path_done_o,
  output logic                      wr_path_done_o,
  output logic [`DATA_W-1:0]        tx_tdata_o,
  output logic [`KEEP_W-1:0]        tx_tkeep_o,
  output logic                      tx_tvalid_o,
  output logic                      tx_tlast_o,
  input  logic                      tx_tready_i
);
  import rdma_resp_pkg::*;

  pkt_job_t push_job;
  pkt_job_t head_job;
  logic     job_push;
  logic     buf_full;
  logic     buf_empty;
  logic     job_pop;

  // header assembly, one job per descriptor
  rdma_resp_seq u_seq (
    .core_clk           (core_clk),
    .core_aresetn       (core_aresetn),
    .conf_of_reg_done_i (conf_of_reg_done_i),
    .local_cfg_i        (local_cfg_i),
    .qp_table_i         (qp_table_i),
    .wqe_tdata_i        (wqe_tdata_i),
    .wqe_tvalid_i       (wqe_tvalid_i),
    .wqe_tlast_i        (wqe_tlast_i),
    .post_rdma_rd_wqe_o (post_rdma_rd_wqe_o),
    .post_rdma_wr_wqe_o (post_rdma_wr_wqe_o),
    .rd_path_done_o     (rd_path_done_o),
    .wr_path_done_o     (wr_path_done_o),
    .buf_full_i         (buf_full),
    .job_push_o         (job_push),
    .job_o              (push_job)
  );

  rdma_pkt_buffer u_buf (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .push_i       (job_push),
    .job_i        (push_job),
    .full_o       (buf_full),
    .pop_i        (job_pop),
    .empty_o      (buf_empty),
    .job_o        (head_job)
  );

  rdma_beat_tx u_tx (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .empty_i      (buf_empty),
    .job_i        (head_job),
    .pop_o        (job_pop),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o),
    .tx_tready_i  (tx_tready_i)
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 3
) (
  output logic core_clk,
  output logic core_aresetn
);
  initial begin
    core_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) core_clk = ~core_clk;
  end

  initial begin
    core_aresetn = 1'b0;
    repeat (RST_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    core_aresetn <= 1'b1;   // released on a falling edge
  end
endmodule

// File: test/rdma_resp_tb.sv
`timescale 1ns/10ps
`include "rdma_resp_macros.svh"

module rdma_resp_tb;
  import rdma_resp_pkg::*;

  localparam int NUM_PKTS       = 16;
  localparam int TIMEOUT_CYCLES = 4 * (NUM_PKTS * (12 + 6) + 48 * 8);

  logic               core_clk;
  logic               core_aresetn;
  logic               conf_of_reg_done_i;
  local_cfg_t         local_cfg_i;
  qp_dest_t           qp_table_i [`QP_TABLE_DEPTH];
  logic [`DATA_W-1:0] wqe_tdata_i;
  logic               wqe_tvalid_i;
  logic               wqe_tlast_i;
  logic               post_rdma_rd_wqe_o;
  logic               post_rdma_wr_wqe_o;
  logic               rd_path_done_o;
  logic               wr_path_done_o;
  logic [`DATA_W-1:0] tx_tdata_o;
  logic [`KEEP_W-1:0] tx_tkeep_o;
  logic               tx_tvalid_o;
  logic               tx_tlast_o;
  logic               tx_tready_i;

  logic [79:0]        test_mem [0:24];   // cfg, qp table, 16 descriptors
  logic [7:0]         exp_hdr [`HDR_BYTES];
  integer             seed;
  int                 desc_ptr;
  int                 desc_wait;
  int                 rd_posts;
  int                 wr_posts;
  int                 pkt_cnt;
  int                 beat_cnt;
  int                 cycle_cnt;
  logic               stall_q;
  logic [`DATA_W-1:0] stall_data;
  logic [`KEEP_W+1:0] stall_ctrl;
  logic               post_any;

  assign post_any = post_rdma_rd_wqe_o || post_rdma_wr_wqe_o;

  tb_clk_gen u_clk (.core_clk(core_clk), .core_aresetn(core_aresetn));

  rdma_resp_top UUT (
    .core_clk           (core_clk),
    .core_aresetn       (core_aresetn),
    .conf_of_reg_done_i (conf_of_reg_done_i),
    .local_cfg_i        (local_cfg_i),
    .qp_table_i         (qp_table_i),
    .wqe_tdata_i        (wqe_tdata_i),
    .wqe_tvalid_i       (wqe_tvalid_i),
    .wqe_tlast_i        (wqe_tlast_i),
    .post_rdma_rd_wqe_o (post_rdma_rd_wqe_o),
    .post_rdma_wr_wqe_o (post_rdma_wr_wqe_o),
    .rd_path_done_o     (rd_path_done_o),
    .wr_path_done_o     (wr_path_done_o),
    .tx_tdata_o         (tx_tdata_o),
    .tx_tkeep_o         (tx_tkeep_o),
    .tx_tvalid_o        (tx_tvalid_o),
    .tx_tlast_o         (tx_tlast_o),
    .tx_tready_i        (tx_tready_i)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else abort_run(what);
  endtask

  task automatic compare_value(input string name, input logic [`DATA_W-1:0] expv,
                               input logic [`DATA_W-1:0] actv);
    assert (actv === expv) else begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expv, actv);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
    end
  endtask

  // big endian field value from wire bytes
  function automatic logic [47:0] field_of(input logic [`DATA_W-1:0] data, input int offset,
                                           input int nbytes);
    logic [47:0] value;
    value = '0;
    for (int i = 0; i < nbytes; i++) begin
      value = {value[39:0], data[(offset + i)*8 +: 8]};
    end
    return value;
  endfunction

  task automatic put_field(input int offset, input int nbytes, input logic [47:0] value);
    for (int i = 0; i < nbytes; i++) begin
      exp_hdr[offset + i] = value[(nbytes - 1 - i)*8 +: 8];
    end
  endtask

  function automatic logic [15:0] header_checksum();
    logic [19:0] acc;
    acc = '0;
    for (int i = 14; i < 34; i += 2) begin
      if (i != 24) acc = acc + {4'h0, exp_hdr[i], exp_hdr[i+1]};   // skip csum field
    end
    acc = {4'h0, acc[15:0]} + {16'h0, acc[19:16]};
    acc = {4'h0, acc[15:0]} + {16'h0, acc[19:16]};
    return ~acc[15:0];
  endfunction

  task automatic build_header(input int pkt);
    logic [79:0] desc;
    logic [79:0] dest;
    logic        is_ack;
    logic [15:0] total_len;
    desc      = test_mem[9 + pkt];
    dest      = test_mem[1 + desc[26:24]];   // low three qp bits pick the entry
    is_ack    = (pkt >= 8);
    total_len = is_ack ? 16'h0030 : 16'h0130;
    for (int i = 0; i < `HDR_BYTES; i++) begin
      exp_hdr[i] = 8'h00;
    end
    put_field(0, 6, dest[79:32]);
    put_field(6, 6, test_mem[0][79:32]);
    put_field(12, 2, 16'h0800);
    put_field(14, 2, 16'h45b8);
    put_field(16, 2, total_len);
    put_field(18, 4, 32'h5555_4000);
    put_field(22, 2, 16'hba11);   // ttl, udp
    put_field(26, 4, test_mem[0][31:0]);
    put_field(30, 4, dest[31:0]);
    put_field(24, 2, header_checksum());
    put_field(34, 4, 32'h6851_12b7);
    put_field(38, 2, is_ack ? 16'h001c : 16'h011c);
    put_field(42, 1, is_ack ? 8'h11 : 8'h10);
    put_field(44, 2, 16'h666f);
    put_field(47, 3, desc[47:24]);
    put_field(51, 3, desc[23:0]);
  endtask

  task automatic present_descriptor(input int k);
    for (int w = 0; w < `DATA_W / 32; w++) begin
      wqe_tdata_i[w*32 +: 32] = $random(seed);   // filler around the fields
    end
    for (int i = 0; i < 3; i++) begin
      wqe_tdata_i[(`DESC_QP_BYTE + i)*8 +: 8]  = test_mem[9 + k][47 - i*8 -: 8];
      wqe_tdata_i[(`DESC_PSN_BYTE + i)*8 +: 8] = test_mem[9 + k][23 - i*8 -: 8];
    end
    wqe_tvalid_i = 1'b1;
    wqe_tlast_i  = 1'b1;
  endtask

  task automatic accept_beat();
    logic [`DATA_W-1:0] exp_data;
    logic [`KEEP_W-1:0] exp_keep;
    logic               exp_last;
    logic               is_ack;
    logic [7:0]         pay;
    string              tag;
    require(pkt_cnt < NUM_PKTS, "a beat was accepted after the last expected packet");
    is_ack   = (pkt_cnt >= 8);
    pay      = 8'h10 + 8'(pkt_cnt % 8 + 1);
    tag      = $sformatf("%s %0d beat %0d", is_ack ? "ack" : "read response",
                         pkt_cnt % 8 + 1, beat_cnt);
    // an ack is one beat and a read response five
    exp_last = is_ack ? (beat_cnt == 0) : (beat_cnt == 4);
    exp_keep = exp_last ? {6'b0, {58{1'b1}}} : {`KEEP_W{1'b1}};
    exp_data = '0;
    if (beat_cnt == 0) build_header(pkt_cnt);
    for (int lane = 0; lane < `KEEP_W; lane++) begin
      if (exp_keep[lane]) begin
        if (beat_cnt == 0 && lane < 58) begin
          exp_data[lane*8 +: 8] = exp_hdr[lane];
        end else begin
          exp_data[lane*8 +: 8] = pay;
        end
      end
    end
    if (beat_cnt == 0) begin
      compare_value({tag, " ipv4 checksum"}, field_of(exp_data, 24, 2),
                    field_of(tx_tdata_o, 24, 2));
      compare_value({tag, " ip total length"}, field_of(exp_data, 16, 2),
                    field_of(tx_tdata_o, 16, 2));
      compare_value({tag, " udp length"}, field_of(exp_data, 38, 2),
                    field_of(tx_tdata_o, 38, 2));
      compare_value({tag, " bth opcode"}, field_of(exp_data, 42, 1),
                    field_of(tx_tdata_o, 42, 1));
      compare_value({tag, " bth qp number"}, field_of(exp_data, 47, 3),
                    field_of(tx_tdata_o, 47, 3));
      compare_value({tag, " bth psn"}, field_of(exp_data, 51, 3),
                    field_of(tx_tdata_o, 51, 3));
    end
    compare_value({tag, " tkeep"}, exp_keep, tx_tkeep_o);
    compare_value({tag, " tlast"}, exp_last, tx_tlast_o);
    compare_value({tag, " tdata"}, exp_data, tx_tdata_o);
    beat_cnt = exp_last ? 0 : beat_cnt + 1;
    if (exp_last) pkt_cnt++;
  endtask

  // work item processor model and tready driven on the falling edge
  always @(negedge core_clk) begin
    if ($time > 0 && !conf_of_reg_done_i) begin
      compare_value("control outputs around reset", 6'b0, {post_rdma_rd_wqe_o,
                    post_rdma_wr_wqe_o, rd_path_done_o, wr_path_done_o, tx_tvalid_o, tx_tlast_o});
    end
    if (core_aresetn) begin
      require(!(post_any && desc_wait != 0),
              "a post pulse came while a descriptor was pending");
      require(!rd_path_done_o || rd_posts == 8,
              "rd_path_done_o rose without exactly 8 read posts");
      require(!wr_path_done_o || wr_posts == 8,
              "wr_path_done_o rose without exactly 8 write posts");
      conf_of_reg_done_i = 1'b1;
      tx_tready_i        = (($random(seed) & 3) != 0);   // low about a quarter of the time
      wqe_tvalid_i       = 1'b0;
      wqe_tlast_i        = 1'b0;
      if (desc_wait > 0) begin
        desc_wait--;
        if (desc_wait == 0) begin
          present_descriptor(desc_ptr);
          desc_ptr++;
        end
      end
      if (post_any) begin
        require(!(post_rdma_rd_wqe_o && post_rdma_wr_wqe_o),
                "read and write posts came together");
        if (post_rdma_rd_wqe_o) begin
          require(!rd_path_done_o, "a read post came after rd_path_done_o rose");
          rd_posts++;
        end else begin
          require(rd_path_done_o && rd_posts == 8,
                  "a write post came before the read phase ended");
          require(!wr_path_done_o, "a write post came after wr_path_done_o rose");
          wr_posts++;
        end
        require(rd_posts + wr_posts <= NUM_PKTS, "more post pulses than descriptors");
        desc_wait = 1 + ({$random(seed)} % 6);
      end
    end
  end

  always @(posedge core_clk) begin
    if (core_aresetn) begin
      cycle_cnt++;
      require(cycle_cnt < TIMEOUT_CYCLES,
              $sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
      if (stall_q) begin
        compare_value("stalled beat tdata", stall_data, tx_tdata_o);
        compare_value("stalled beat valid, last, keep", stall_ctrl,
                      {tx_tvalid_o, tx_tlast_o, tx_tkeep_o});
      end
      if (tx_tvalid_o && tx_tready_i) accept_beat();
      stall_q    = tx_tvalid_o && !tx_tready_i;
      stall_data = tx_tdata_o;
      stall_ctrl = {tx_tvalid_o, tx_tlast_o, tx_tkeep_o};
    end
  end

  initial begin
    seed               = 32'h55c7a9ba;
    conf_of_reg_done_i = 1'b0;
    wqe_tdata_i        = '0;
    wqe_tvalid_i       = 1'b0;
    wqe_tlast_i        = 1'b0;
    tx_tready_i        = 1'b0;
    desc_ptr           = 0;
    desc_wait          = 0;
    rd_posts           = 0;
    wr_posts           = 0;
    pkt_cnt            = 0;
    beat_cnt           = 0;
    cycle_cnt          = 0;
    stall_q            = 1'b0;
    $readmemh("test/rdma_resp_testdata.txt", test_mem);
    require(^test_mem[24] !== 1'bx, "the test data file is missing or incomplete");
    local_cfg_i = test_mem[0];
    for (int i = 0; i < `QP_TABLE_DEPTH; i++) begin
      qp_table_i[i] = test_mem[1 + i];
    end
    wait (pkt_cnt == NUM_PKTS && wr_path_done_o);
    repeat (24) @(posedge core_clk);   // idle tail for stray posts or beats
    if (rd_path_done_o && wr_path_done_o && !tx_tvalid_o) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("a done flag dropped or a beat was still valid at the end of the run");
      $display("Checks failed");
      $fatal(1, "simulation stopped");
    end
  end
endmodule

// File: test/rdma_resp_testdata.txt
// row 0: local src mac (48b), src ip (32b); rows 1-8: qp table dst mac (48b), dst ip (32b)
// rows 9-24: descriptors, 32 zero bits, qp number (24b), psn (24b); 8 read then 8 write
020a35001001c0a80a01
3cfdfe0a0000c0a80a20
3cfdfe0a0101c0a80a21
3cfdfe0a0202c0a80a22
3cfdfe0a0303ac100005
3cfdfe0a0404ac100006
0c42a1b7e9f5c0a80a25
3cfdfe0a0606ffffffff
3cfdfe0a070700000001
00000000000011a13b00
00000000000012000001
000000000a0c05ffffff
00000000000017123456
00000000000010000000
000000003f0c0e7fffff
00000000000013abcdef
00000000800004001000
00000000000021a13b08
00000000ffffff000010
00000000000026555555
00000000000020fffffe
00000000000024010203
00000000000023c0ffee
00000000000025800000
00000000000022deadbe

// File: rdma_resp.f
+incdir+verilog
verilog/rdma_resp_pkg.sv
verilog/rdma_resp_seq.sv
verilog/rdma_pkt_buffer.sv
verilog/rdma_beat_tx.sv
verilog/rdma_resp_top.sv
test/tb_clk_gen.sv
test/rdma_resp_tb.sv

// File: Bender.yml
package:
  name: rdma_resp

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rdma_resp_pkg.sv
      - verilog/rdma_resp_seq.sv
      - verilog/rdma_pkt_buffer.sv
      - verilog/rdma_beat_tx.sv
      - verilog/rdma_resp_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clk_gen.sv
      - test/rdma_resp_tb.sv
